//--- build.f
logic/cpu_pkg.sv
logic/cpu_alu.sv
logic/opcode_decoder.sv
logic/timing_control.sv
logic/register_file.sv
logic/cpu_core.sv
dv/cpu_core_tb.sv

//--- Bender.yml
package:
  name: cpu_core

sources:
  - logic/cpu_pkg.sv
  - logic/cpu_alu.sv
  - logic/opcode_decoder.sv
  - logic/timing_control.sv
  - logic/register_file.sv
  - logic/cpu_core.sv
  - target: test
    files:
      - dv/cpu_core_tb.sv

//--- dv/cpu_core_tb.sv
`timescale 1ns/10ps
`default_nettype none

module cpu_core_tb;

    localparam logic [15:0] RST_VECTOR = 16'hfffc;
    localparam logic [15:0] DONE_ADDR  = 16'h00ff;
    // about 600 cycles of programs and resets, three times that with margin
    localparam int CYCLE_LIMIT = 2000;

    logic        clk;
    logic        rst;
    logic [7:0]  data_i;
    logic [15:0] addr_o;
    logic [7:0]  dor_o;
    logic        rw_o;
    logic        sync_o;
    logic        jam_o;

    logic [7:0]  mem [0:65535];
    logic [31:0] rng;
    logic [15:0] org;
    int          errors;
    int          tests_run;
    int          cycles;

    // memory model, read is combinational and write lands on the rising edge
    assign data_i = $isunknown(addr_o) ? 8'h00 : mem[addr_o];

    always @(posedge clk) begin
        if (rw_o === 1'b0) begin
            mem[addr_o] <= dor_o;
        end
    end

    cpu_core #(
        .RST_VECTOR (RST_VECTOR)
    ) cpu_core_i (
        .clk    (clk),
        .rst    (rst),
        .data_i (data_i),
        .addr_o (addr_o),
        .dor_o  (dor_o),
        .rw_o   (rw_o),
        .sync_o (sync_o),
        .jam_o  (jam_o)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #50 clk = ~clk;
        end
    end

    initial begin
        cycles = 0;
        while (cycles < CYCLE_LIMIT) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout after %0d cycles, a program never finished", CYCLE_LIMIT);
        $display("tests run: %0d, errors: %0d", tests_run, errors + 1);
        $display("Something failed");
        $finish;
    end

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic random_byte(output logic [7:0] b);
        rng = xorshift(rng);
        b = rng[7:0];
    endtask

    // opcode bits 7:5 of ORA, AND, EOR, ADC and SBC
    function automatic logic [2:0] acc_group(input int op);
        case (op)
            0: return 3'b000;
            1: return 3'b001;
            2: return 3'b010;
            3: return 3'b011;
            default: return 3'b111;
        endcase
    endfunction

    // binary 6502 accumulator result with the carry out on top
    function automatic logic [8:0] acc_result(input int op, input logic [7:0] a,
                                              input logic [7:0] b, input logic c);
        int r;
        case (op)
            0: r = a | b;
            1: r = a & b;
            2: r = a ^ b;
            3: r = int'(a) + int'(b) + (c ? 1 : 0);
            default: r = int'(a) - int'(b) - (c ? 0 : 1);
        endcase
        if (op == 3) begin
            return {r > 255, r[7:0]};
        end
        // borrow is the inverted carry
        return {r >= 0, r[7:0]};
    endfunction

    // cycles per instruction of the timing program
    function automatic int timing_gap(input int i);
        case (i)
            0, 1, 5, 7: return 2;
            default: return 3;
        endcase
    endfunction

    task automatic report_mismatch(input string test, input logic [15:0] expected,
                                   input logic [15:0] actual);
        errors++;
        $display("Fail %s: expected %0h, actual %0h", test, expected, actual);
    endtask

    task automatic fill_memory();
        for (int i = 0; i < 65536; i++) begin
            mem[i] <= 8'(i ^ (i >> 8) ^ 8'h3c);
        end
    endtask

    task automatic emit(input logic [7:0] b);
        mem[org] <= b;
        org = org + 16'd1;
    endtask

    task automatic emit2(input logic [7:0] op, input logic [7:0] arg);
        emit(op);
        emit(arg);
    endtask

    task automatic start_program(input logic [15:0] start);
        mem[RST_VECTOR] <= start[7:0];
        mem[RST_VECTOR + 16'd1] <= start[15:8];
        org = start;
    endtask

    // store to the done address, then spin on a jump to itself
    task automatic emit_done_store();
        logic [15:0] here;
        emit2(8'h86, DONE_ADDR[7:0]);
        here = org;
        emit(8'h4c);
        emit2(here[7:0], here[15:8]);
    endtask

    // one reset per test
    task automatic begin_reset();
        @(posedge clk);
        rst <= 1'b1;
        @(posedge clk);
        tests_run++;
        fill_memory();
    endtask

    task automatic end_reset();
        repeat (4) @(posedge clk);
        rst <= 1'b0;
    endtask

    task automatic wait_for_done();
        @(negedge clk);
        while (!(rw_o === 1'b0 && addr_o === DONE_ADDR)) begin
            @(negedge clk);
        end
        // write completes on the next rising edge
        @(negedge clk);
    endtask

    task automatic reset_fetch_test();
        begin_reset();
        start_program(16'h0400);
        emit(8'hea);
        emit_done_store();
        @(negedge clk);
        if (rw_o !== 1'b1 || sync_o !== 1'b0 || jam_o !== 1'b0) begin
            errors++;
            $display("reset_fetch: outputs not at their reset levels while rst is high");
        end
        end_reset();
        @(negedge clk);
        if (addr_o !== RST_VECTOR) report_mismatch("reset_fetch low", RST_VECTOR, addr_o);
        if (rw_o !== 1'b1 || sync_o !== 1'b0) begin
            errors++;
            $display("reset_fetch: write or sync during the first vector read");
        end
        @(negedge clk);
        if (addr_o !== RST_VECTOR + 16'd1) begin
            report_mismatch("reset_fetch high", RST_VECTOR + 16'd1, addr_o);
        end
        if (rw_o !== 1'b1 || sync_o !== 1'b0) begin
            errors++;
            $display("reset_fetch: write or sync during the second vector read");
        end
        @(negedge clk);
        if (addr_o !== 16'h0400) report_mismatch("reset_fetch target", 16'h0400, addr_o);
        if (sync_o !== 1'b1 || rw_o !== 1'b1) begin
            errors++;
            $display("reset_fetch: no opcode fetch at the vector target");
        end
        wait_for_done();
    endtask

    task automatic load_store_test();
        logic [7:0] a;
        logic [7:0] x;
        logic [7:0] y;
        random_byte(a);
        random_byte(x);
        random_byte(y);
        begin_reset();
        start_program(16'h0400);
        emit2(8'ha9, a);
        emit2(8'ha2, x);
        emit2(8'ha0, y);
        emit2(8'h85, 8'h20);
        emit2(8'h86, 8'h21);
        emit2(8'h84, 8'h22);
        // reload crosswise from zero page
        emit2(8'ha6, 8'h20);
        emit2(8'ha4, 8'h21);
        emit2(8'ha5, 8'h22);
        emit2(8'h86, 8'h23);
        emit2(8'h84, 8'h24);
        emit2(8'h85, 8'h25);
        // increments, decrements and transfers
        emit(8'he8);
        emit(8'h88);
        emit2(8'h86, 8'h26);
        emit2(8'h84, 8'h27);
        emit(8'h8a);
        emit(8'ha8);
        emit(8'hc8);
        emit(8'h98);
        emit(8'haa);
        emit(8'hca);
        emit2(8'h85, 8'h28);
        emit2(8'h86, 8'h29);
        emit_done_store();
        end_reset();
        wait_for_done();
        if (mem[16'h0020] !== a) report_mismatch("load_store STA", a, mem[16'h0020]);
        if (mem[16'h0021] !== x) report_mismatch("load_store STX", x, mem[16'h0021]);
        if (mem[16'h0022] !== y) report_mismatch("load_store STY", y, mem[16'h0022]);
        if (mem[16'h0023] !== a) report_mismatch("load_store LDX zp", a, mem[16'h0023]);
        if (mem[16'h0024] !== x) report_mismatch("load_store LDY zp", x, mem[16'h0024]);
        if (mem[16'h0025] !== y) report_mismatch("load_store LDA zp", y, mem[16'h0025]);
        if (mem[16'h0026] !== 8'(a + 1)) begin
            report_mismatch("load_store INX", 8'(a + 1), mem[16'h0026]);
        end
        if (mem[16'h0027] !== 8'(x - 1)) begin
            report_mismatch("load_store DEY", 8'(x - 1), mem[16'h0027]);
        end
        if (mem[16'h0028] !== 8'(a + 2)) begin
            report_mismatch("load_store TXA TAY INY TYA", 8'(a + 2), mem[16'h0028]);
        end
        if (mem[16'h0029] !== 8'(a + 1)) begin
            report_mismatch("load_store TAX DEX", 8'(a + 1), mem[16'h0029]);
        end
    endtask

    task automatic arith_test();
        logic [7:0] a [20];
        logic [7:0] b [20];
        logic       c [20];
        logic [7:0] r;
        logic [8:0] expected;
        begin_reset();
        start_program(16'h0400);
        for (int k = 0; k < 20; k++) begin
            random_byte(a[k]);
            random_byte(b[k]);
            random_byte(r);
            c[k] = r[0];
            emit(c[k] ? 8'h38 : 8'h18);
            emit2(8'ha9, a[k]);
            // first half immediate, second half zero page
            if (k < 10) begin
                emit2({acc_group(k % 5), 5'b01001}, b[k]);
            end else begin
                mem[16'h0040 + k] <= b[k];
                emit2({acc_group(k % 5), 5'b00101}, 8'h40 + 8'(k));
            end
            emit2(8'h85, 8'h80 + 8'(k));
        end
        emit_done_store();
        end_reset();
        wait_for_done();
        for (int k = 0; k < 20; k++) begin
            expected = acc_result(k % 5, a[k], b[k], c[k]);
            if (mem[16'h0080 + k] !== expected[7:0]) begin
                report_mismatch($sformatf("arith op %0d case %0d", k % 5, k),
                                expected[7:0], mem[16'h0080 + k]);
            end
        end
    endtask

    task automatic branch_test();
        logic [7:0]  a;
        logic [7:0]  b;
        logic [7:0]  br;
        logic [8:0]  sum;
        logic [15:0] next;
        logic        z;
        logic        c;
        logic        cin;
        logic        taken [12];
        begin_reset();
        start_program(16'h0400);
        // not-taken marker in X, taken marker in Y
        emit2(8'ha2, 8'h55);
        emit2(8'ha0, 8'haa);
        c = 1'b0;
        z = 1'b0;
        for (int k = 0; k < 12; k++) begin
            random_byte(a);
            random_byte(b);
            case (k % 3)
                0: begin
                    if (k % 2 == 0) begin
                        b = a;
                    end
                    emit2(8'ha9, a);
                    emit2(8'hc9, b);
                    z = (a == b);
                    c = (a >= b);
                end
                1: begin
                    emit2(8'ha9, 8'h00);
                    z = 1'b1;
                end
                default: begin
                    if (k == 2) begin
                        {a, b} = 16'h8080;
                    end else if (k == 5) begin
                        {a, b} = 16'h7f01;
                    end
                    cin = ((k / 3) % 2 == 1);
                    emit(cin ? 8'h38 : 8'h18);
                    emit2(8'ha9, a);
                    emit2(8'h69, b);
                    sum = acc_result(3, a, b, cin);
                    z = (sum[7:0] == 8'h00);
                    c = sum[8];
                end
            endcase
            case (k % 4)
                0: begin
                    br = 8'hf0;
                    taken[k] = z;
                end
                1: begin
                    br = 8'hd0;
                    taken[k] = !z;
                end
                2: begin
                    br = 8'h90;
                    taken[k] = !c;
                end
                default: begin
                    br = 8'hb0;
                    taken[k] = c;
                end
            endcase
            // taken skips the X store and the jump over the Y store
            emit2(br, 8'd5);
            emit2(8'h86, 8'ha0 + 8'(k));
            next = org + 16'd5;
            emit(8'h4c);
            emit2(next[7:0], next[15:8]);
            emit2(8'h84, 8'ha0 + 8'(k));
        end
        emit_done_store();
        end_reset();
        wait_for_done();
        for (int k = 0; k < 12; k++) begin
            if (mem[16'h00a0 + k] !== (taken[k] ? 8'haa : 8'h55)) begin
                report_mismatch($sformatf("branch case %0d", k),
                                taken[k] ? 8'haa : 8'h55, mem[16'h00a0 + k]);
            end
        end
    endtask

    task automatic timing_jam_test();
        int          sync_cycle [$];
        logic [15:0] sync_addr [$];
        logic [15:0] store_addr;
        int          store_cycle;
        int          cyc;
        begin_reset();
        start_program(16'h0200);
        mem[16'h0010] <= 8'h5a;
        emit(8'hea);
        emit2(8'ha9, 8'h00);
        emit2(8'ha5, 8'h10);
        emit2(8'h85, 8'h11);
        emit(8'h4c);
        emit2(8'h00, 8'h03);
        org = 16'h0300;
        // BEQ falls through, BNE jumps over two bytes
        emit2(8'hf0, 8'h02);
        emit2(8'hd0, 8'h02);
        org = 16'h0306;
        emit(8'haa);
        emit(8'h02);
        end_reset();
        cyc = 0;
        store_cycle = -1;
        store_addr = 16'h0000;
        do begin
            @(negedge clk);
            cyc++;
            if (sync_o === 1'b1) begin
                sync_cycle.push_back(cyc);
                sync_addr.push_back(addr_o);
            end
            if (rw_o === 1'b0) begin
                store_cycle = cyc;
                store_addr = addr_o;
            end
        end while (jam_o !== 1'b1);
        if (sync_cycle.size() != 9) begin
            errors++;
            $display("timing: %0d opcode fetches before the jam, 9 expected", sync_cycle.size());
        end else begin
            for (int i = 0; i < 8; i++) begin
                if (sync_cycle[i + 1] - sync_cycle[i] != timing_gap(i)) begin
                    report_mismatch($sformatf("timing instruction %0d", i), timing_gap(i),
                                    sync_cycle[i + 1] - sync_cycle[i]);
                end
            end
            if (sync_addr[5] !== 16'h0300) report_mismatch("timing JMP", 16'h0300, sync_addr[5]);
            if (sync_addr[7] !== 16'h0306) report_mismatch("timing BNE", 16'h0306, sync_addr[7]);
            if (store_cycle != sync_cycle[3] + 2) begin
                report_mismatch("timing store cycle", sync_cycle[3] + 2, store_cycle);
            end
            if (cyc - sync_cycle[8] != 2) report_mismatch("jam delay", 2, cyc - sync_cycle[8]);
        end
        if (store_addr !== 16'h0011) report_mismatch("timing store address", 16'h0011, store_addr);
        if (mem[16'h0011] !== 8'h5a) report_mismatch("timing store data", 8'h5a, mem[16'h0011]);
        repeat (20) begin
            @(negedge clk);
            if (sync_o !== 1'b0 || jam_o !== 1'b1) begin
                errors++;
                $display("jam: core left the jam state without a reset");
            end
        end
    endtask

    initial begin
        rst = 1'b1;
        rng = 32'd47743;
        errors = 0;
        tests_run = 0;
        org = 16'h0000;
        fill_memory();
        reset_fetch_test();
        load_store_test();
        arith_test();
        branch_test();
        timing_jam_test();
        $display("tests run: %0d, errors: %0d", tests_run, errors);
        if (errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- logic/cpu_core.sv
`timescale 1ns/10ps
`default_nettype none

module cpu_core
    import cpu_pkg::*;
#(
    parameter logic [15:0] RST_VECTOR  = 16'hfffc,
    // interrupt disable and bit 5 set
    parameter logic [7:0]  INIT_STATUS = 8'h24
) (
    input  wire logic       clk,
    input  wire logic       rst,
    input  wire logic [7:0] data_i,
    output logic [15:0]     addr_o,
    output logic [7:0]      dor_o,
    output logic            rw_o,
    output logic            sync_o,
    output logic            jam_o
);

    // second vector byte, read right after the reset vector itself
    localparam logic [15:0] VEC_HI = RST_VECTOR + 16'd1;

    logic [15:0] pc, pc_next;
    logic [7:0]  ir, data, adl, adh;
    logic [7:0]  p, store_val, set_mask, clear_mask;
    logic        inc_pc, jump, load_ir, exec, write_mem;
    logic        up_nz, up_cv;
    addr_src_t   adl_src, adh_src;
    op_class_t   op_class;
    alu_op_t     alu_op;
    reg_sel_t    src_sel, dst_sel;

    function automatic logic [7:0] addr_byte(
        input addr_src_t  src,
        input logic [7:0] pc_b,
        input logic [7:0] vec_b,
        input logic [7:0] rd_b,
        input logic [7:0] held_b
    );
        case (src)
            ADDR_DATA: return rd_b;
            ADDR_ZERO: return 8'h00;
            ADDR_VEC:  return vec_b;
            ADDR_HOLD: return held_b;
            default:   return pc_b;
        endcase
    endfunction

    // on jump the held byte is a signed branch offset
    assign pc_next = pc + (jump ? {{8{data[7]}}, data} : {15'b0, inc_pc});
    assign adl = addr_byte(adl_src, pc_next[7:0], VEC_HI[7:0], data_i, data);
    assign adh = addr_byte(adh_src, pc_next[15:8], VEC_HI[15:8], data_i, data);

    always_ff @(posedge clk) begin
        if (rst) begin
            addr_o <= RST_VECTOR;
            pc     <= RST_VECTOR;
            rw_o   <= 1'b1;
        end else begin
            addr_o <= {adh, adl};
            pc     <= jump ? {adh, adl} : pc_next;
            rw_o   <= !write_mem;
        end
    end

    // data latch, instruction register, write data
    always_ff @(posedge clk) begin
        data  <= data_i;
        dor_o <= store_val;
        if (load_ir) begin
            ir <= data_i;
        end
    end

    timing_control timing_control_i (
        .clk         (clk),
        .rst         (rst),
        .data_i      (data_i),
        .op_class    (op_class),
        .p           (p),
        .branch_bits (ir[7:5]),
        .adl_src     (adl_src),
        .adh_src     (adh_src),
        .inc_pc      (inc_pc),
        .jump        (jump),
        .load_ir     (load_ir),
        .exec        (exec),
        .write_mem   (write_mem),
        .sync_o      (sync_o),
        .jam_o       (jam_o)
    );

    opcode_decoder opcode_decoder_i (
        .ir         (ir),
        .op_class   (op_class),
        .alu_op     (alu_op),
        .src_sel    (src_sel),
        .dst_sel    (dst_sel),
        .up_nz      (up_nz),
        .up_cv      (up_cv),
        .set_mask   (set_mask),
        .clear_mask (clear_mask)
    );

    register_file #(
        .INIT_STATUS (INIT_STATUS)
    ) register_file_i (
        .clk        (clk),
        .rst        (rst),
        .exec       (exec),
        .src_sel    (src_sel),
        .dst_sel    (dst_sel),
        .alu_op     (alu_op),
        .up_nz      (up_nz),
        .up_cv      (up_cv),
        .set_mask   (set_mask),
        .clear_mask (clear_mask),
        .data       (data_i),
        .store_sel  (src_sel),
        .p          (p),
        .store_o    (store_val)
    );

    // a store never overlaps the next opcode fetch
    assert property (@(posedge clk) disable iff (rst) sync_o |-> rw_o)
        else $error("write during opcode fetch at %h", addr_o);

endmodule

`default_nettype wire

//--- logic/register_file.sv
`timescale 1ns/10ps
`default_nettype none

module register_file
    import cpu_pkg::*;
#(
    parameter logic [7:0] INIT_STATUS = 8'h24
) (
    input  wire logic       clk,
    input  wire logic       rst,
    input  wire logic       exec,
    input  wire reg_sel_t   src_sel,
    input  wire reg_sel_t   dst_sel,
    input  wire alu_op_t    alu_op,
    input  wire logic       up_nz,
    input  wire logic       up_cv,
    input  wire logic [7:0] set_mask,
    input  wire logic [7:0] clear_mask,
    input  wire logic [7:0] data,
    input  wire reg_sel_t   store_sel,
    output logic [7:0]      p,
    output logic [7:0]      store_o
);

    localparam logic [7:0] P_ONES  = 8'(1 << FL_U);
    localparam logic [7:0] P_ZEROS = 8'(1 << FL_B);

    logic [7:0] a, x, y;
    logic [7:0] ai, result, p_next;
    logic       carry, overflow, compare, ci;

    always_comb begin
        case (src_sel)
            REG_A:   ai = a;
            REG_X:   ai = x;
            REG_Y:   ai = y;
            default: ai = data;
        endcase
        case (store_sel)
            REG_A:   store_o = a;
            REG_X:   store_o = x;
            REG_Y:   store_o = y;
            default: store_o = data;
        endcase
    end

    // compare is a subtract with no destination
    assign compare = (alu_op == ALU_SUB) && (dst_sel == REG_M);
    assign ci      = compare | p[FL_C];

    cpu_alu alu_i (
        .op         (alu_op),
        .ai         (ai),
        .bi         (data),
        .ci         (ci),
        .out        (result),
        .carry_o    (carry),
        .overflow_o (overflow)
    );

    always_comb begin
        p_next = ~clear_mask & (set_mask | p);
        if (up_cv) begin
            p_next[FL_C] = carry;
            if (!compare) begin
                p_next[FL_V] = overflow;
            end
        end
        if (up_nz) begin
            p_next[FL_Z] = (result == 8'h00);
            p_next[FL_N] = result[7];
        end
        p_next = (p_next | P_ONES) & ~P_ZEROS;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            a <= 8'h00;
            x <= 8'h00;
            y <= 8'h00;
            p <= (INIT_STATUS | P_ONES) & ~P_ZEROS;
        end else if (exec) begin
            p <= p_next;
            case (dst_sel)
                REG_A:   a <= result;
                REG_X:   x <= result;
                REG_Y:   y <= result;
                default: ;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- logic/timing_control.sv
`timescale 1ns/10ps
`default_nettype none

module timing_control
    import cpu_pkg::*;
(
    input  wire logic       clk,
    input  wire logic       rst,
    input  wire logic [7:0] data_i,
    input  wire op_class_t  op_class,
    input  wire logic [7:0] p,
    input  wire logic [2:0] branch_bits,
    output addr_src_t       adl_src,
    output addr_src_t       adh_src,
    output logic            inc_pc,
    output logic            jump,
    output logic            load_ir,
    output logic            exec,
    output logic            write_mem,
    output logic            sync_o,
    output logic            jam_o
);

    tstate_t state, state_next;
    logic    two_cycle;
    logic    flag;
    logic    taken;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= TRST1;
        end else begin
            state <= state_next;
        end
    end

    assign sync_o = (state == T1);
    assign jam_o  = (state == TJAM);

    // predecode on the opcode byte: immediate and implied skip T2
    assign two_cycle = (data_i ==? 8'b???_010_?0) || (data_i ==? 8'b???_010_01) ||
                       (data_i ==? 8'b101_000_?0) || (data_i ==? 8'b???_110_00);

    // opcode bits 7:6 pick the flag, bit 5 the value that takes the branch
    always_comb begin
        case (branch_bits[2:1])
            2'b00:   flag = p[FL_N];
            2'b01:   flag = p[FL_V];
            2'b10:   flag = p[FL_C];
            default: flag = p[FL_Z];
        endcase
        taken = (flag == branch_bits[0]);
    end

    always_comb begin
        state_next = TJAM;
        adl_src    = ADDR_PC;
        adh_src    = ADDR_PC;
        inc_pc     = 1'b0;
        jump       = 1'b0;
        load_ir    = 1'b0;
        exec       = 1'b0;
        write_mem  = 1'b0;

        case (state)
            TRST1: begin
                {adh_src, adl_src} = {ADDR_VEC, ADDR_VEC};
                state_next = TRST2;
            end
            TRST2: begin
                // high byte on the bus, low byte held from last cycle
                {adh_src, adl_src} = {ADDR_DATA, ADDR_HOLD};
                jump       = 1'b1;
                state_next = T1;
            end
            T1: begin
                inc_pc  = 1'b1;
                load_ir = 1'b1;
                if (two_cycle) begin
                    state_next = T0T2;
                end else begin
                    state_next = T2;
                end
            end
            T0T2: begin
                if (op_class == OP_IMP || op_class == OP_IMM) begin
                    exec       = 1'b1;
                    inc_pc     = (op_class == OP_IMM);
                    state_next = T1;
                end
            end
            T2: begin
                inc_pc = 1'b1;
                case (op_class)
                    OP_ZRD, OP_ZST: begin
                        {adh_src, adl_src} = {ADDR_ZERO, ADDR_DATA};
                        write_mem  = (op_class == OP_ZST);
                        state_next = T0;
                    end
                    OP_JMP: state_next = T3;
                    OP_BRA: begin
                        if (taken) begin
                            state_next = T3;
                        end else begin
                            state_next = T1;
                        end
                    end
                    default: state_next = TJAM;
                endcase
            end
            T3: begin
                // branch keeps pc sources, the core adds the offset on jump
                jump = 1'b1;
                if (op_class == OP_JMP) begin
                    {adh_src, adl_src} = {ADDR_DATA, ADDR_HOLD};
                end
                state_next = T1;
            end
            T0: begin
                exec       = (op_class == OP_ZRD);
                state_next = T1;
            end
            default: state_next = TJAM;
        endcase
    end

    assert property (@(posedge clk) disable iff (rst) $onehot0(state))
        else $error("timing state not one-hot: %b", state);

endmodule

`default_nettype wire

//--- logic/opcode_decoder.sv
`timescale 1ns/10ps
`default_nettype none

module opcode_decoder
    import cpu_pkg::*;
(
    input  wire logic [7:0] ir,
    output op_class_t       op_class,
    output alu_op_t         alu_op,
    output reg_sel_t        src_sel,
    output reg_sel_t        dst_sel,
    output logic            up_nz,
    output logic            up_cv,
    output logic [7:0]      set_mask,
    output logic [7:0]      clear_mask
);

    localparam logic [7:0] C_BIT = 8'(1 << FL_C);

    always_comb begin
        op_class   = OP_BAD;
        alu_op     = ALU_PASS;
        src_sel    = REG_M;
        dst_sel    = REG_M;
        up_nz      = 1'b0;
        up_cv      = 1'b0;
        set_mask   = 8'h00;
        clear_mask = 8'h00;

        casez (ir)
            // accumulator group, zero page or immediate
            8'b???_001_01, 8'b???_010_01: begin
                if (ir[3]) begin
                    op_class = OP_IMM;
                end else begin
                    op_class = OP_ZRD;
                end
                src_sel = REG_A;
                dst_sel = REG_A;
                up_nz   = 1'b1;
                case (ir[7:5])
                    3'b000: alu_op = ALU_ORA;
                    3'b001: alu_op = ALU_AND;
                    3'b010: alu_op = ALU_EOR;
                    3'b011: begin
                        alu_op = ALU_SUM;
                        up_cv  = 1'b1;
                    end
                    3'b100: begin
                        // STA, no immediate form
                        if (ir[3]) begin
                            op_class = OP_BAD;
                        end else begin
                            op_class = OP_ZST;
                        end
                        dst_sel = REG_M;
                        up_nz   = 1'b0;
                    end
                    3'b101: src_sel = REG_M;
                    3'b110: begin
                        // compare keeps A
                        alu_op  = ALU_SUB;
                        dst_sel = REG_M;
                        up_cv   = 1'b1;
                    end
                    default: begin
                        alu_op = ALU_SUB;
                        up_cv  = 1'b1;
                    end
                endcase
            end
            // LDX / LDY
            8'b101_00?_?0: begin
                if (ir[2]) begin
                    op_class = OP_ZRD;
                end else begin
                    op_class = OP_IMM;
                end
                dst_sel = ir[1] ? REG_X : REG_Y;
                up_nz   = 1'b1;
            end
            // STX / STY
            8'b100_001_?0: begin
                op_class = OP_ZST;
                src_sel  = ir[1] ? REG_X : REG_Y;
            end
            8'h4c: op_class = OP_JMP;
            8'b1??_100_00: op_class = OP_BRA;
            8'he8, 8'hc8, 8'hca, 8'h88: begin
                op_class = OP_IMP;
                // INX and INY have bit 6 set and bit 1 clear
                alu_op   = (ir[6] && !ir[1]) ? ALU_INC : ALU_DEC;
                if (ir == 8'hca || ir == 8'he8) begin
                    src_sel = REG_X;
                end else begin
                    src_sel = REG_Y;
                end
                dst_sel = src_sel;
                up_nz   = 1'b1;
            end
            // register transfers
            8'haa, 8'h8a, 8'ha8, 8'h98: begin
                op_class = OP_IMP;
                up_nz    = 1'b1;
                case (ir)
                    8'haa: {src_sel, dst_sel} = {REG_A, REG_X};
                    8'h8a: {src_sel, dst_sel} = {REG_X, REG_A};
                    8'ha8: {src_sel, dst_sel} = {REG_A, REG_Y};
                    default: {src_sel, dst_sel} = {REG_Y, REG_A};
                endcase
            end
            8'h18: begin
                op_class   = OP_IMP;
                clear_mask = C_BIT;
            end
            8'h38: begin
                op_class = OP_IMP;
                set_mask = C_BIT;
            end
            8'hea: op_class = OP_IMP;
            default: op_class = OP_BAD;
        endcase
    end

endmodule

`default_nettype wire

//--- logic/cpu_alu.sv
`timescale 1ns/10ps
`default_nettype none

module cpu_alu
    import cpu_pkg::*;
(
    input  wire alu_op_t    op,
    input  wire logic [7:0] ai,
    input  wire logic [7:0] bi,
    input  wire logic       ci,
    output logic [7:0]      out,
    output logic            carry_o,
    output logic            overflow_o
);

    logic [7:0] b_eff;
    logic [8:0] sum;
    logic       arith;

    // subtract is add of the inverted operand, borrow is inverted carry
    assign b_eff = (op == ALU_SUB) ? ~bi : bi;
    assign sum   = {1'b0, ai} + {1'b0, b_eff} + {8'h00, ci};
    assign arith = (op == ALU_SUM) || (op == ALU_SUB);

    always_comb begin
        case (op)
            ALU_SUM, ALU_SUB: out = sum[7:0];
            ALU_AND:  out = ai & bi;
            ALU_ORA:  out = ai | bi;
            ALU_EOR:  out = ai ^ bi;
            ALU_INC:  out = ai + 8'd1;
            ALU_DEC:  out = ai - 8'd1;
            default:  out = ai;
        endcase
        carry_o = arith & sum[8];
        // signed overflow when both inputs agree in sign and the result does not
        overflow_o = arith & (ai[7] == b_eff[7]) & (sum[7] != ai[7]);
    end

    always_comb begin
        if (!$isunknown({op, ai, bi, ci})) begin
            assert final (!$isunknown({out, carry_o, overflow_o}))
                else $error("alu output unknown for op %0d", op);
        end
    end

endmodule

`default_nettype wire

//--- logic/cpu_pkg.sv
`default_nettype none

package cpu_pkg;

    // one-hot timing states, all zeros is the jam state
    typedef enum logic [7:0] {
        TJAM  = 8'h00,
        T0    = 8'h01,
        T3    = 8'h02,
        T2    = 8'h04,
        T0T2  = 8'h08,
        T1    = 8'h10,
        TRST2 = 8'h20,
        TRST1 = 8'h40
    } tstate_t;

    // opcode classes seen by the timing FSM
    typedef enum logic [3:0] {
        OP_IMP,
        OP_IMM,
        OP_ZRD,
        OP_ZST,
        OP_JMP,
        OP_BRA,
        OP_BAD
    } op_class_t;

    typedef enum logic [2:0] {
        ALU_SUM,
        ALU_SUB,
        ALU_AND,
        ALU_ORA,
        ALU_EOR,
        ALU_INC,
        ALU_DEC,
        ALU_PASS
    } alu_op_t;

    // source of one address byte for the next cycle
    typedef enum logic [2:0] {
        ADDR_PC,
        ADDR_DATA,
        ADDR_ZERO,
        ADDR_VEC,
        ADDR_HOLD
    } addr_src_t;

    // REG_M is the byte read from memory
    typedef enum logic [1:0] {
        REG_A,
        REG_X,
        REG_Y,
        REG_M
    } reg_sel_t;

    // status register bit positions
    localparam int FL_C = 0;
    localparam int FL_Z = 1;
    localparam int FL_B = 4;
    localparam int FL_U = 5;
    localparam int FL_V = 6;
    localparam int FL_N = 7;

endpackage

`default_nettype wire
